//--- bch_decoder.f
+incdir+logic
logic/bch_pkg.sv
logic/bch_syndrome.sv
logic/bch_berlekamp_ribm.sv
logic/bch_codeword_buffer.sv
logic/bch_chien_search.sv
logic/bch_decoder.sv
verification/bch_decoder_assert.sv
verification/bch_decoder_tb.sv

//--- Bender.yml
package:
  name: bch_decoder

export_include_dirs:
  - logic

sources:
  - logic/bch_pkg.sv
  - logic/bch_syndrome.sv
  - logic/bch_berlekamp_ribm.sv
  - logic/bch_codeword_buffer.sv
  - logic/bch_chien_search.sv
  - logic/bch_decoder.sv
  - target: simulation
    files:
      - verification/bch_decoder_assert.sv
      - verification/bch_decoder_tb.sv

//--- verification/bch_decoder_tb.sv
//--------------------------------------------------
// table driven testbench for the (15,5) decoder
// messages are encoded with g(x) = 0x537, errors
// added from a mask, words sent msb first
// at most 3 errors per entry, count checked on oeop
//--------------------------------------------------
`timescale 1ns/10ps
`include "bch_settings.svh"

module bch_decoder_tb
  import bch_pkg::*;
();

  localparam int          num_vec     = 14;
  localparam int          cycle_limit = num_vec * 40;
  localparam logic [10:0] gen_poly    = 11'h537;

  // one stimulus entry
  typedef struct packed {
    logic [4:0]  msg;
    logic [14:0] mask;
    logic        stall;
  } vec_t;

  logic iclk;
  logic ireset;
  logic iclkena;
  logic ibit_val;
  logic ibit;
  logic isop;
  logic obit_val;
  logic obit;
  logic osop;
  logic oeop;
  cnt_t oerr_cnt;

  vec_t        tbl [0:num_vec-1];
  integer      seed;
  int          words_done;
  int          ena_cnt;
  logic [14:0] exp_word_q [$];
  int          exp_cnt_q  [$];
  int          last_q     [$];

  bch_decoder i_bch_decoder (
    .iclk     (iclk),
    .ireset   (ireset),
    .iclkena  (iclkena),
    .ibit_val (ibit_val),
    .ibit     (ibit),
    .isop     (isop),
    .obit_val (obit_val),
    .obit     (obit),
    .osop     (osop),
    .oeop     (oeop),
    .oerr_cnt (oerr_cnt)
  );

  initial begin
    iclk = 1'b0;
    forever #10 iclk = ~iclk;
  end

  //--------------------------------------------------
  // helpers
  //--------------------------------------------------
  // message times generator over GF(2)
  function automatic logic [14:0] encode(input logic [4:0] msg);
    logic [14:0] cw;
    cw = '0;
    for (int i = 0; i < 5; i++) begin
      if (msg[i]) begin
        cw = cw ^ (15'(gen_poly) << i);
      end
    end
    return cw;
  endfunction

  function automatic int count_ones(input logic [14:0] v);
    int n;
    n = 0;
    for (int i = 0; i < `BCH_N; i++) begin
      n = n + int'(v[i]);
    end
    return n;
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("ERROR at %0t: %s got %0h expected %0h", $time, name, actual, expected);
      $display("TEST FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic fail_run(input string what);
    $display("ERROR at %0t: %s", $time, what);
    $display("TEST FAILED");
    $fatal(1, "run aborted");
  endtask

  // stalled entries drop the enable about one cycle in four
  task pick_ena(input logic stall);
    if (stall) begin
      iclkena <= (($random(seed) & 3) != 0);
    end else begin
      iclkena <= 1'b1;
    end
  endtask

  task idle_cycle(input logic stall);
    ibit_val <= 1'b0;
    isop     <= 1'b0;
    pick_ena(stall);
    @(posedge iclk);
  endtask

  // each bit is held until an enabled edge takes it
  task automatic send_word(input logic [14:0] cw, input logic stall);
    int i;
    i = `BCH_N - 1;
    while (i >= 0) begin
      ibit_val <= 1'b1;
      ibit     <= cw[i];
      isop     <= (i == `BCH_N - 1);
      pick_ena(stall);
      @(posedge iclk);
      if (iclkena) begin
        i--;
      end
    end
  endtask

  task load_table;
    // clean, then single errors at first, last and middle
    tbl[0]  = {5'h13, 15'h0000, 1'b0};
    tbl[1]  = {5'h1f, 15'h4000, 1'b0};
    tbl[2]  = {5'h0a, 15'h0001, 1'b0};
    tbl[3]  = {5'h05, 15'h0080, 1'b0};
    // double and triple
    tbl[4]  = {5'h16, 15'h4001, 1'b0};
    tbl[5]  = {5'h19, 15'h0120, 1'b0};
    tbl[6]  = {5'h07, 15'h4081, 1'b0};
    tbl[7]  = {5'h1c, 15'h2804, 1'b0};
    // back to back run
    tbl[8]  = {5'h00, 15'h0000, 1'b0};
    tbl[9]  = {5'h11, 15'h1010, 1'b0};
    tbl[10] = {5'h03, 15'h0c02, 1'b0};
    // enable stalls
    tbl[11] = {5'h1e, 15'h0200, 1'b1};
    tbl[12] = {5'h0f, 15'h6000, 1'b1};
    tbl[13] = {5'h15, 15'h0000, 1'b1};
  endtask

  //--------------------------------------------------
  // stimulus
  //--------------------------------------------------
  initial begin
    int          gap;
    logic [14:0] cw;
    seed       = 32'hc155ea90;
    words_done = 0;
    ena_cnt    = 0;
    iclkena    = 1'b1;
    ireset     = 1'b1;
    ibit_val   = 1'b0;
    ibit       = 1'b0;
    isop       = 1'b0;
    load_table();
    repeat (2) @(posedge iclk);
    ireset <= 1'b0;
    for (int k = 0; k < num_vec; k++) begin
      cw = encode(tbl[k].msg);
      exp_word_q.push_back(cw);
      exp_cnt_q.push_back(count_ones(tbl[k].mask));
      send_word(cw ^ tbl[k].mask, tbl[k].stall);
      // entries 7..9 are followed without a gap
      if (k >= 7 && k <= 9) begin
        gap = 0;
      end else begin
        gap = {$random(seed)} % 4;
      end
      repeat (gap) idle_cycle(tbl[k].stall);
    end
    // drain the pipeline
    while (words_done < num_vec) begin
      idle_cycle(tbl[num_vec-1].stall);
    end
    // one more edge for the last framing checks
    idle_cycle(tbl[num_vec-1].stall);
    if (i_bch_decoder.i_assert.fail_cnt == 0) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      fail_run("framing assertion failed on the decoder output");
    end
  end

  //--------------------------------------------------
  // collector, samples on enabled edges only
  //--------------------------------------------------
  initial begin
    logic [14:0] word;
    int          nbits;
    int          in_bits;
    word    = '0;
    nbits   = 0;
    in_bits = 0;
    forever begin
      @(posedge iclk);
      if (!ireset && iclkena) begin
        // note the enabled edge of each last input bit
        if (ibit_val) begin
          in_bits = isop ? 1 : in_bits + 1;
          if (in_bits == `BCH_N) begin
            last_q.push_back(ena_cnt);
          end
        end
        if (obit_val) begin
          if (osop) begin
            word  = '0;
            nbits = 0;
            if (last_q.size() == 0) begin
              fail_run("output word started before any input word ended");
            end else begin
              check_value("osop latency", ena_cnt - last_q.pop_front(), 10);
            end
          end
          word = {word[13:0], obit};
          nbits++;
          if (oeop) begin
            if (exp_word_q.size() == 0) begin
              fail_run("more output words than words sent");
            end else begin
              check_value("obit count", nbits, `BCH_N);
              check_value("obit word", word, exp_word_q.pop_front());
              check_value("oerr_cnt", oerr_cnt, exp_cnt_q.pop_front());
              words_done++;
            end
          end
        end
        ena_cnt++;
      end
    end
  end

  // watchdog and framing monitor
  initial begin
    int cycles;
    cycles = 0;
    forever begin
      @(posedge iclk);
      cycles++;
      if (i_bch_decoder.i_assert.fail_cnt != 0) begin
        fail_run("framing assertion failed on the decoder output");
      end else if (cycles > cycle_limit) begin
        fail_run("timeout, not all words came out of the decoder");
      end
    end
  end

endmodule

//--- verification/bch_decoder_assert.sv
//--------------------------------------------------
// output framing checks, bound into bch_decoder
// all cycle counts are enabled cycles only
//--------------------------------------------------
`timescale 1ns/10ps

module bch_decoder_assert (
  input logic iclk,
  input logic ireset,
  input logic iclkena,
  input logic obit_val,
  input logic osop,
  input logic oeop
);

  logic       in_word;
  logic [4:0] cyc_cnt;
  // number of failed assertions
  int         fail_cnt = 0;

  // position tracking from osop up to oeop
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      in_word <= 1'b0;
      cyc_cnt <= '0;
    end else if (iclkena) begin
      if (osop) begin
        in_word <= 1'b1;
        cyc_cnt <= 5'd1;
      end else if (oeop) begin
        in_word <= 1'b0;
      end else if (in_word) begin
        cyc_cnt <= cyc_cnt + 1'b1;
      end
    end
  end

  // no hole inside a word
  a_no_gap : assert property (@(posedge iclk) disable iff (ireset)
    iclkena && in_word |-> obit_val)
  else begin
    fail_cnt++;
    $error("gap inside output word");
  end

  // osop only on a fresh valid bit
  a_sop_fresh : assert property (@(posedge iclk) disable iff (ireset)
    iclkena && osop |-> obit_val && !in_word)
  else begin
    fail_cnt++;
    $error("osop inside a word");
  end

  // last bit 14 cycles after osop
  a_eop_pos : assert property (@(posedge iclk) disable iff (ireset)
    iclkena && oeop |-> in_word && cyc_cnt == 5'd14)
  else begin
    fail_cnt++;
    $error("oeop misplaced");
  end

  // valid bits only inside a framed word, so 15 per osop
  a_val_framed : assert property (@(posedge iclk) disable iff (ireset)
    iclkena && obit_val |-> osop || in_word)
  else begin
    fail_cnt++;
    $error("valid bit outside a word");
  end

  a_reset_low : assert property (@(posedge iclk)
    $fell(ireset) |-> !obit_val && !osop && !oeop)
  else begin
    fail_cnt++;
    $error("strobes high after reset");
  end

endmodule

bind bch_decoder bch_decoder_assert i_assert (
  .iclk     (iclk),
  .ireset   (ireset),
  .iclkena  (iclkena),
  .obit_val (obit_val),
  .osop     (osop),
  .oeop     (oeop)
);

//--- logic/bch_decoder.sv
//--------------------------------------------------
// (15,5) BCH decoder top, up to 3 errors per word
// no back-pressure, at most one bit per enabled cycle
// 10 enabled cycles from last input to first output
//--------------------------------------------------
`timescale 1ns/10ps

module bch_decoder
  import bch_pkg::*;
(
  input  logic iclk,
  input  logic ireset,
  input  logic iclkena,
  input  logic ibit_val,
  input  logic ibit,
  input  logic isop,
  output logic obit_val,
  output logic obit,
  output logic osop,
  output logic oeop,
  output cnt_t oerr_cnt
);

  logic      syn_val;
  syndrome_t syn;
  ptr_t      syn_ptr;
  pos_t      wr_pos;
  ptr_t      wr_ptr;
  logic      loc_val;
  loc_poly_t loc;
  ptr_t      loc_ptr;
  ptr_t      rd_ptr;
  pos_t      rd_pos;
  logic      rd_bit;

  //--------------------------------------------------
  // syndromes and raw bit store
  //--------------------------------------------------
  bch_syndrome i_syndrome (
    .iclk     (iclk),
    .ireset   (ireset),
    .iclkena  (iclkena),
    .ibit_val (ibit_val),
    .ibit     (ibit),
    .isop     (isop),
    .osyn_val (syn_val),
    .osyn     (syn),
    .osyn_ptr (syn_ptr),
    .owr_pos  (wr_pos),
    .owr_ptr  (wr_ptr)
  );

  bch_codeword_buffer i_buffer (
    .iclk    (iclk),
    .iclkena (iclkena),
    .iwr_val (ibit_val),
    .iwr_bit (ibit),
    .iwr_ptr (wr_ptr),
    .iwr_pos (wr_pos),
    .ird_ptr (rd_ptr),
    .ird_pos (rd_pos),
    .ord_bit (rd_bit)
  );

  //--------------------------------------------------
  // key equation and correction
  //--------------------------------------------------
  bch_berlekamp_ribm i_berlekamp (
    .iclk     (iclk),
    .ireset   (ireset),
    .iclkena  (iclkena),
    .isyn_val (syn_val),
    .isyn     (syn),
    .isyn_ptr (syn_ptr),
    .oloc_val (loc_val),
    .oloc     (loc),
    .oloc_ptr (loc_ptr)
  );

  bch_chien_search i_chien (
    .iclk     (iclk),
    .ireset   (ireset),
    .iclkena  (iclkena),
    .iloc_val (loc_val),
    .iloc     (loc),
    .iloc_ptr (loc_ptr),
    .ird_bit  (rd_bit),
    .ord_ptr  (rd_ptr),
    .ord_pos  (rd_pos),
    .obit_val (obit_val),
    .obit     (obit),
    .osop     (osop),
    .oeop     (oeop),
    .oerr_cnt (oerr_cnt)
  );

endmodule

//--- logic/bch_chien_search.sv
//--------------------------------------------------
// chien search and bit correction
// sweeps positions n-1 down to 0, one per cycle
// output stream starts 2 cycles after iloc_val
// oerr_cnt valid with oeop, saturates nowhere
//--------------------------------------------------
`timescale 1ns/10ps
`include "bch_settings.svh"

module bch_chien_search
  import bch_pkg::*;
(
  input  logic      iclk,
  input  logic      ireset,
  input  logic      iclkena,
  input  logic      iloc_val,
  input  loc_poly_t iloc,
  input  ptr_t      iloc_ptr,
  input  logic      ird_bit,
  output ptr_t      ord_ptr,
  output pos_t      ord_pos,
  output logic      obit_val,
  output logic      obit,
  output logic      osop,
  output logic      oeop,
  output cnt_t      oerr_cnt
);

  gf_t  coef [0:`BCH_T];
  gf_t  term [0:`BCH_T];
  gf_t  sum;
  logic active;
  logic err_flag;
  logic err_d;

  assign coef[0] = iloc.c0;
  assign coef[1] = iloc.c1;
  assign coef[2] = iloc.c2;
  assign coef[3] = iloc.c3;

  // locator value at alpha^-pos
  always_comb begin
    sum = '0;
    for (int i = 0; i <= `BCH_T; i++) begin
      sum = sum ^ term[i];
    end
  end

  assign err_flag = active & (sum == '0);

  //--------------------------------------------------
  // stage 1, address and evaluation
  //--------------------------------------------------
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      active   <= 1'b0;
      ord_pos  <= '0;
      ord_ptr  <= 1'b0;
      obit_val <= 1'b0;
      osop     <= 1'b0;
      oeop     <= 1'b0;
      err_d    <= 1'b0;
      oerr_cnt <= '0;
    end else if (iclkena) begin
      if (iloc_val) begin
        active  <= 1'b1;
        ord_pos <= pos_t'(`BCH_N-1);
        ord_ptr <= iloc_ptr;
      end else if (active) begin
        if (ord_pos == '0) begin
          active <= 1'b0;
        end else begin
          ord_pos <= ord_pos - 1'b1;
        end
      end
      // stage 2 lines up with buffer read data
      obit_val <= active;
      osop     <= active & (ord_pos == pos_t'(`BCH_N-1));
      oeop     <= active & (ord_pos == '0);
      err_d    <= err_flag;
      if (active) begin
        if (ord_pos == pos_t'(`BCH_N-1)) begin
          oerr_cnt <= cnt_t'(err_flag);
        end else begin
          oerr_cnt <= oerr_cnt + cnt_t'(err_flag);
        end
      end
    end
  end

  //--------------------------------------------------
  // running terms, lambda_i * alpha^(-i*pos)
  //--------------------------------------------------
  always_ff @(posedge iclk) begin
    if (iclkena) begin
      for (int i = 0; i <= `BCH_T; i++) begin
        if (iloc_val) begin
          // alpha^(-14 i) equals alpha^i
          term[i] <= gf_mult(coef[i], gf_alpha_pow(i));
        end else if (active) begin
          // pos falls by one so the point moves by alpha
          term[i] <= gf_mult(term[i], gf_alpha_pow(i));
        end
      end
    end
  end

  // flip where the locator has a root
  assign obit = ird_bit ^ err_d;

endmodule

//--- logic/bch_codeword_buffer.sv
//--------------------------------------------------
// two bank bit store for received words
// one bank is filled while the other is read
// read data appears one enabled cycle after address
// caller keeps positions below n
//--------------------------------------------------
`timescale 1ns/10ps
`include "bch_settings.svh"

module bch_codeword_buffer
  import bch_pkg::*;
(
  input  logic iclk,
  input  logic iclkena,
  input  logic iwr_val,
  input  logic iwr_bit,
  input  ptr_t iwr_ptr,
  input  pos_t iwr_pos,
  input  ptr_t ird_ptr,
  input  pos_t ird_pos,
  output logic ord_bit
);

  // bank per tag, bit per position
  logic [`BCH_N-1:0] mem [0:1];

  //--------------------------------------------------
  // write port
  //--------------------------------------------------
  always_ff @(posedge iclk) begin
    if (iclkena && iwr_val) begin
      mem[iwr_ptr][iwr_pos] <= iwr_bit;
    end
  end

  //--------------------------------------------------
  // registered read port
  //--------------------------------------------------
  always_ff @(posedge iclk) begin
    if (iclkena) begin
      ord_bit <= mem[ird_ptr][ird_pos];
    end
  end

endmodule

//--- logic/bch_berlekamp_ribm.sv
//--------------------------------------------------
// simplified inversionless berlekamp-massey for
// binary codes, t iterations as step1/step2 pairs
// oloc_val comes 2t+1 cycles after isyn_val
// syndromes seen while busy are dropped
// locator is known only up to a nonzero scale
//--------------------------------------------------
`timescale 1ns/10ps
`include "bch_settings.svh"

module bch_berlekamp_ribm
  import bch_pkg::*;
(
  input  logic      iclk,
  input  logic      ireset,
  input  logic      iclkena,
  input  logic      isyn_val,
  input  syndrome_t isyn,
  input  ptr_t      isyn_ptr,
  output logic      oloc_val,
  output loc_poly_t oloc,
  output ptr_t      oloc_ptr
);

  // delta and theta span indices 0 .. 3t
  localparam int top = `BCH_T2 + 3;

  typedef enum logic [1:0] {
    st_reset,
    st_wait,
    st_step1,
    st_step2
  } state_t;

  state_t state;

  gf_t               delta [0:top];
  gf_t               theta [0:top];
  gf_t               syn   [0:`BCH_T2-1];
  gf_t               gam;
  gf_t               d0;
  logic              sw;
  logic [`BCH_M-1:0] kv;
  logic [1:0]        cnt;
  logic              swap;

  assign syn[0] = isyn.s1;
  assign syn[1] = isyn.s2;
  assign syn[2] = isyn.s3;
  assign syn[3] = isyn.s4;
  assign syn[4] = isyn.s5;
  assign syn[5] = isyn.s6;

  // swap when discrepancy is nonzero and k >= 0
  assign swap = (delta[0] != '0) & ~kv[`BCH_M-1];

  //--------------------------------------------------
  // FSM and control
  //--------------------------------------------------
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      state    <= st_reset;
      cnt      <= '0;
      oloc_val <= 1'b0;
      oloc_ptr <= 1'b0;
    end else if (iclkena) begin
      oloc_val <= (state == st_step2) & (cnt == 2'd1);
      case (state)
        st_reset: state <= st_wait;
        st_wait: begin
          cnt <= 2'(`BCH_T);
          if (isyn_val) begin
            oloc_ptr <= isyn_ptr;
            state    <= st_step1;
          end
        end
        st_step1: state <= st_step2;
        st_step2: begin
          cnt   <= cnt - 1'b1;
          state <= (cnt == 2'd1) ? st_wait : st_step1;
        end
        default: state <= st_reset;
      endcase
    end
  end

  //--------------------------------------------------
  // datapath
  //--------------------------------------------------
  always_ff @(posedge iclk) begin
    if (iclkena) begin
      unique case (state)
        st_wait: begin
          if (isyn_val) begin
            for (int i = 0; i <= top; i++) begin
              if (i < `BCH_T2) begin
                delta[i] <= syn[i];
                theta[i] <= syn[i];
              end else begin
                delta[i] <= gf_t'(i == top);
                theta[i] <= gf_t'(i == top);
              end
            end
            gam <= gf_t'(1);
            kv  <= '0;
          end
        end
        st_step1: begin
          // two plain steps folded, the odd one has zero discrepancy
          for (int i = 0; i <= top - 2; i++) begin
            delta[i] <= gf_mult(gam, delta[i+2]) ^ gf_mult(delta[0], theta[i+1]);
          end
          delta[top-1] <= gf_mult(delta[0], theta[top]);
          delta[top]   <= '0;
          if (swap) begin
            for (int i = 0; i < top; i++) begin
              theta[i] <= delta[i+1];
            end
            theta[top] <= '0;
          end
          d0 <= delta[0];
          sw <= swap;
        end
        st_step2: begin
          // gamma and k follow the decision of step1
          if (sw) begin
            gam <= d0;
            kv  <= -kv;
          end else begin
            kv  <= kv + 2'd2;
          end
        end
        default: begin
        end
      endcase
    end
  end

  // locator sits at delta t .. 2t
  assign oloc.c0 = delta[`BCH_T];
  assign oloc.c1 = delta[`BCH_T+1];
  assign oloc.c2 = delta[`BCH_T+2];
  assign oloc.c3 = delta[`BCH_T+3];

endmodule

//--- logic/bch_syndrome.sv
//--------------------------------------------------
// serial syndrome calculator
// bits come highest degree first, isop on the first
// bits outside a word (no isop seen) are ignored
// osyn is valid only while osyn_val is high
//--------------------------------------------------
`timescale 1ns/10ps
`include "bch_settings.svh"

module bch_syndrome
  import bch_pkg::*;
(
  input  logic      iclk,
  input  logic      ireset,
  input  logic      iclkena,
  input  logic      ibit_val,
  input  logic      ibit,
  input  logic      isop,
  output logic      osyn_val,
  output syndrome_t osyn,
  output ptr_t      osyn_ptr,
  output pos_t      owr_pos,
  output ptr_t      owr_ptr
);

  gf_t  acc [1:`BCH_T2];
  pos_t cnt;
  logic busy;
  ptr_t ptr;
  logic take;
  logic last;

  // current bit position, first bit is degree n-1
  assign owr_pos = isop ? pos_t'(`BCH_N-1) : cnt;
  assign owr_ptr = ptr;

  assign take = ibit_val & (isop | busy);
  assign last = take & (owr_pos == '0);

  //--------------------------------------------------
  // control
  //--------------------------------------------------
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      cnt      <= '0;
      busy     <= 1'b0;
      ptr      <= 1'b0;
      osyn_val <= 1'b0;
      osyn_ptr <= 1'b0;
    end else if (iclkena) begin
      osyn_val <= last;
      if (take) begin
        cnt  <= owr_pos - 1'b1;
        busy <= ~last;
      end
      // tag of finished word goes out, next word takes the other bank
      if (last) begin
        osyn_ptr <= ptr;
        ptr      <= ~ptr;
      end
    end
  end

  //--------------------------------------------------
  // horner accumulation, acc_j = acc_j * alpha^j + r
  //--------------------------------------------------
  always_ff @(posedge iclk) begin
    if (iclkena && take) begin
      for (int j = 1; j <= `BCH_T2; j++) begin
        if (isop) begin
          acc[j] <= gf_t'(ibit);
        end else begin
          acc[j] <= gf_mult(acc[j], gf_alpha_pow(j)) ^ gf_t'(ibit);
        end
      end
    end
  end

  assign osyn.s1 = acc[1];
  assign osyn.s2 = acc[2];
  assign osyn.s3 = acc[3];
  assign osyn.s4 = acc[4];
  assign osyn.s5 = acc[5];
  assign osyn.s6 = acc[6];

endmodule

//--- logic/bch_pkg.sv
//--------------------------------------------------
// shared types and GF(2^4) helpers for the decoder
// multiply and power are plain combinational loops
// and are meant for constant or shallow use
//--------------------------------------------------
`include "bch_settings.svh"

package bch_pkg;

  // one field element
  typedef logic [`BCH_M-1:0]     gf_t;
  // word tag, selects a buffer bank
  typedef logic                  ptr_t;
  // bit position inside a word
  typedef logic [`BCH_POS_W-1:0] pos_t;
  // number of corrected bits, up to t
  typedef logic [1:0]            cnt_t;

  // s1 sits at the low end
  typedef struct packed {
    gf_t s6;
    gf_t s5;
    gf_t s4;
    gf_t s3;
    gf_t s2;
    gf_t s1;
  } syndrome_t;

  // locator coefficients, c0 at the low end
  typedef struct packed {
    gf_t c3;
    gf_t c2;
    gf_t c1;
    gf_t c0;
  } loc_poly_t;

  // shift and add product, reduced by the primitive polynomial
  function automatic gf_t gf_mult(input gf_t a, input gf_t b);
    logic [`BCH_M:0] acc;
    logic [`BCH_M:0] sh;
    acc = '0;
    sh  = {1'b0, a};
    for (int i = 0; i < `BCH_M; i++) begin
      if (b[i]) begin
        acc = acc ^ sh;
      end
      sh = sh << 1;
      if (sh[`BCH_M]) begin
        sh = sh ^ (`BCH_M+1)'(`BCH_IRRPOL);
      end
    end
    return acc[`BCH_M-1:0];
  endfunction

  // alpha^e, e taken modulo the field order
  function automatic gf_t gf_alpha_pow(input int e);
    gf_t r;
    r = gf_t'(1);
    for (int i = 0; i < (e % `BCH_N); i++) begin
      r = gf_mult(r, gf_t'(2));
    end
    return r;
  endfunction

endpackage

//--- logic/bch_settings.svh
//--------------------------------------------------
// fixed code parameters for the (15,5) binary BCH
// decoder, t = 3 over GF(2^4)
// changing these alone does not retarget the design
// since the pipeline timing assumes n = 15, t = 3
//--------------------------------------------------
`ifndef BCH_SETTINGS_SVH
`define BCH_SETTINGS_SVH

// field width in bits
`define BCH_M       4

// code length
`define BCH_N       15

// correction capability and syndrome count
`define BCH_T       3
`define BCH_T2      6

// x^4 + x + 1
`define BCH_IRRPOL  19

// bit position counter width
`define BCH_POS_W   4

`endif
